//--- Makefile
SIM      = verilator
TOP      = tb_dbg_wb_subsys
FILELIST = all.f
FLAGS    = --binary --timing -Wno-fatal --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hdl/dbg_pkg.sv
hdl/wb_pkg.sv
hdl/dbg_cmd_dispatch.sv
hdl/dbg_biu_wb.sv
hdl/wb_master_arbiter.sv
hdl/dbg_wb_subsys.sv
verif/wb_mem_slave.sv
verif/tb_dbg_wb_subsys.sv

//--- hdl/dbg_biu_wb.sv
`timescale 1ns/100ps

/*
  One bus-interface unit carrying a single transfer between biu_clk_i and
  wb_clk_i with toggle synchronizers. The host must wait for rdy_o before the
  next strobe. rdata_o and err_o only change while rdy_o is low.
*/
module dbg_biu_wb (
  input  logic                       biu_clk_i,
  input  logic                       biu_rst_i,
  input  logic                       wb_clk_i,
  input  logic                       wb_rst,
  input  dbg_pkg::dbg_xfer_t         xfer_i,
  input  logic                       strb_i,
  output logic                       rdy_o,
  output logic [dbg_pkg::DBG_DW-1:0] rdata_o,
  output logic                       err_o,
  output wb_pkg::wb_req_t            wb_req_o,
  input  wb_pkg::wb_rsp_t            wb_rsp_i
);

  typedef enum logic {
    IDLE,
    TRANSFER
  } wb_state_e;

  // Debug domain
  dbg_pkg::dbg_xfer_t xfer_q;
  logic               accept;
  logic               start_tgl;
  logic [1:0]         done_sync;
  logic               done_sync_q;
  logic               done_edge;

  // Wishbone domain
  wb_state_e                  state_q;
  logic [1:0]                 start_sync;
  logic                       start_sync_q;
  logic                       start_edge;
  logic                       wb_resp;
  logic                       done_tgl;
  logic [dbg_pkg::DBG_DW-1:0] rdata_shift;

  ////////////////////////////////////////////////////////////
  // Debug clock domain
  ////////////////////////////////////////////////////////////

  assign accept = strb_i & rdy_o;

  // Held stable for the wb side until ready returns
  always_ff @(posedge biu_clk_i) begin
    if (accept) begin
      xfer_q <= xfer_i;
    end
  end

  // Start toggle out, done toggle back in
  always_ff @(posedge biu_clk_i or posedge biu_rst_i) begin
    if (biu_rst_i) begin
      start_tgl   <= 1'b0;
      done_sync   <= 2'b00;
      done_sync_q <= 1'b0;
      rdy_o       <= 1'b1;
    end else begin
      done_sync   <= {done_sync[0], done_tgl};
      done_sync_q <= done_sync[1];
      if (accept) begin
        start_tgl <= ~start_tgl;
        rdy_o     <= 1'b0;
      end else if (done_edge) begin
        rdy_o <= 1'b1;
      end
    end
  end

  // Any change of the done toggle ends the transfer
  assign done_edge = done_sync[1] ^ done_sync_q;

  ////////////////////////////////////////////////////////////
  // Wishbone clock domain
  ////////////////////////////////////////////////////////////

  // Two flops plus one for edge detect
  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      start_sync   <= 2'b00;
      start_sync_q <= 1'b0;
    end else begin
      start_sync   <= {start_sync[0], start_tgl};
      start_sync_q <= start_sync[1];
    end
  end

  assign start_edge = start_sync[1] ^ start_sync_q;

  // Response only counts while our cycle is open
  assign wb_resp = (state_q == TRANSFER) & (wb_rsp_i.ack | wb_rsp_i.err);

  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_edge) begin
            state_q <= TRANSFER;
          end
        end
        TRANSFER: begin
          if (wb_resp) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // cyc and stb follow the state, rest comes from the latched transfer
  always_comb begin
    wb_req_o.cyc = (state_q == TRANSFER);
    wb_req_o.stb = (state_q == TRANSFER);
    wb_req_o.we  = xfer_q.we;
    wb_req_o.adr = xfer_q.addr;
    wb_req_o.dat = xfer_q.wdata;
    wb_req_o.sel = xfer_q.sel;
  end

  // Move the selected lane down to bit 0 with zeros above
  always_comb begin
    case (xfer_q.sel)
      4'b0001: rdata_shift = {24'h0, wb_rsp_i.dat[7:0]};
      4'b0010: rdata_shift = {24'h0, wb_rsp_i.dat[15:8]};
      4'b0100: rdata_shift = {24'h0, wb_rsp_i.dat[23:16]};
      4'b1000: rdata_shift = {24'h0, wb_rsp_i.dat[31:24]};
      4'b0011: rdata_shift = {16'h0, wb_rsp_i.dat[15:0]};
      4'b1100: rdata_shift = {16'h0, wb_rsp_i.dat[31:16]};
      default: rdata_shift = wb_rsp_i.dat;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_resp) begin
      rdata_o <= rdata_shift;
    end
  end

  // Error level and done toggle back to the debug side
  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      err_o    <= 1'b0;
      done_tgl <= 1'b0;
    end else if (wb_resp) begin
      err_o    <= wb_rsp_i.err;
      done_tgl <= ~done_tgl;
    end
  end

endmodule

//--- hdl/dbg_cmd_dispatch.sv
`timescale 1ns/100ps

/*
  Host-side front end in the biu_clk_i domain. Ready, data and error shown
  to the host always belong to the unit named in the current command.
  Sub-word write data are expected in the top bits of wdata.
*/
module dbg_cmd_dispatch (
  input  logic                                 biu_clk_i,
  input  logic                                 wb_rst,
  input  dbg_pkg::dbg_req_t                    dbg_req_i,
  input  logic                                 dbg_strb_i,
  input  logic [dbg_pkg::NUM_UNITS-1:0]        unit_rdy_i,
  input  logic [dbg_pkg::DBG_DW-1:0]           unit_rdata_i [dbg_pkg::NUM_UNITS],
  input  logic [dbg_pkg::NUM_UNITS-1:0]        unit_err_i,
  output logic                                 biu_rst_o,
  output dbg_pkg::dbg_xfer_t                   xfer_o,
  output logic [dbg_pkg::NUM_UNITS-1:0]        unit_strb_o,
  output logic                                 dbg_rdy_o,
  output logic [dbg_pkg::DBG_DW-1:0]           dbg_rdata_o,
  output logic                                 dbg_err_o
);

  logic [1:0] rst_sync;

  // Assert at once, release after two debug clocks
  always_ff @(posedge biu_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      rst_sync <= 2'b11;
    end else begin
      rst_sync <= {rst_sync[0], 1'b0};
    end
  end

  assign biu_rst_o = rst_sync[1];

  // Byte select decode and write lane placement, shared by all units
  always_comb begin
    xfer_o.addr = dbg_req_i.addr;
    xfer_o.we   = dbg_req_i.we;
    case (dbg_req_i.size)
      dbg_pkg::SZ_BYTE: begin
        xfer_o.sel   = 4'b0001 << dbg_req_i.addr[1:0];
        xfer_o.wdata = {24'h0, dbg_req_i.wdata[31:24]} << {dbg_req_i.addr[1:0], 3'b000};
      end
      dbg_pkg::SZ_HALF: begin
        xfer_o.sel   = 4'b0011 << {dbg_req_i.addr[1], 1'b0};
        xfer_o.wdata = {16'h0, dbg_req_i.wdata[31:16]} << {dbg_req_i.addr[1], 4'b0000};
      end
      // Word size and any unknown code give a full word access
      default: begin
        xfer_o.sel   = 4'b1111;
        xfer_o.wdata = dbg_req_i.wdata;
      end
    endcase
  end

  // Strobe goes only to the addressed unit
  always_comb begin
    for (int i = 0; i < dbg_pkg::NUM_UNITS; i++) begin
      unit_strb_o[i] = dbg_strb_i & (int'(dbg_req_i.unit) == i);
    end
  end

  // Status back from the same unit
  assign dbg_rdy_o   = unit_rdy_i[dbg_req_i.unit];
  assign dbg_rdata_o = unit_rdata_i[dbg_req_i.unit];
  assign dbg_err_o   = unit_err_i[dbg_req_i.unit];

endmodule

//--- hdl/dbg_pkg.sv
/*
  Debug-side constants and command types shared by the dispatcher and the BIUs.
  Data path is fixed at 32 bits and little-endian. Size codes other than
  1 and 2 are treated as a full word access.
*/
package dbg_pkg;

  // Number of bus-interface units and width of their index
  localparam int NUM_UNITS = 2;
  localparam int UNIT_W    = 1;

  // Debug address and data widths
  localparam int DBG_AW = 32;
  localparam int DBG_DW = 32;

  // Word size codes as issued by the host
  localparam logic [2:0] SZ_BYTE = 3'd1;
  localparam logic [2:0] SZ_HALF = 3'd2;
  localparam logic [2:0] SZ_WORD = 3'd4;

  // One host command
  typedef struct packed {
    logic [UNIT_W-1:0] unit;
    logic [DBG_AW-1:0] addr;
    logic [DBG_DW-1:0] wdata;
    logic              we;
    logic [2:0]        size;
  } dbg_req_t;

  // One decoded transfer, write data already in its byte lanes
  typedef struct packed {
    logic [DBG_AW-1:0]   addr;
    logic [DBG_DW-1:0]   wdata;
    logic [DBG_DW/8-1:0] sel;
    logic                we;
  } dbg_xfer_t;

endpackage

//--- hdl/dbg_wb_subsys.sv
`timescale 1ns/100ps

/*
  Wishbone side of the debug unit. Host commands arrive in the biu_clk_i
  domain and leave on one classic Wishbone master port in wb_clk_i.
  wb_rst is asynchronous and is resynchronized for the debug domain.
*/
module dbg_wb_subsys (
  input  logic                       wb_clk_i,
  input  logic                       biu_clk_i,
  input  logic                       wb_rst,
  input  dbg_pkg::dbg_req_t          dbg_req_i,
  input  logic                       dbg_strb_i,
  output logic                       dbg_rdy_o,
  output logic [dbg_pkg::DBG_DW-1:0] dbg_rdata_o,
  output logic                       dbg_err_o,
  output wb_pkg::wb_req_t            wb_req_o,
  input  wb_pkg::wb_rsp_t            wb_rsp_i
);

  logic                          biu_rst;
  dbg_pkg::dbg_xfer_t            xfer;
  logic [dbg_pkg::NUM_UNITS-1:0] unit_strb;
  logic [dbg_pkg::NUM_UNITS-1:0] unit_rdy;
  logic [dbg_pkg::NUM_UNITS-1:0] unit_err;
  logic [dbg_pkg::DBG_DW-1:0]    unit_rdata [dbg_pkg::NUM_UNITS];
  wb_pkg::wb_req_t               unit_req [dbg_pkg::NUM_UNITS];
  wb_pkg::wb_rsp_t               unit_rsp [dbg_pkg::NUM_UNITS];

  // Decode and route in the debug domain
  dbg_cmd_dispatch i_dispatch (
    .biu_clk_i    (biu_clk_i),
    .wb_rst       (wb_rst),
    .dbg_req_i    (dbg_req_i),
    .dbg_strb_i   (dbg_strb_i),
    .unit_rdy_i   (unit_rdy),
    .unit_rdata_i (unit_rdata),
    .unit_err_i   (unit_err),
    .biu_rst_o    (biu_rst),
    .xfer_o       (xfer),
    .unit_strb_o  (unit_strb),
    .dbg_rdy_o    (dbg_rdy_o),
    .dbg_rdata_o  (dbg_rdata_o),
    .dbg_err_o    (dbg_err_o)
  );

  // One unit per index, all sharing the decoded transfer
  for (genvar g = 0; g < dbg_pkg::NUM_UNITS; g++) begin : g_unit
    dbg_biu_wb i_biu (
      .biu_clk_i (biu_clk_i),
      .biu_rst_i (biu_rst),
      .wb_clk_i  (wb_clk_i),
      .wb_rst    (wb_rst),
      .xfer_i    (xfer),
      .strb_i    (unit_strb[g]),
      .rdy_o     (unit_rdy[g]),
      .rdata_o   (unit_rdata[g]),
      .err_o     (unit_err[g]),
      .wb_req_o  (unit_req[g]),
      .wb_rsp_i  (unit_rsp[g])
    );
  end

  // Single master port onto the bus
  wb_master_arbiter i_arbiter (
    .wb_clk_i   (wb_clk_i),
    .wb_rst     (wb_rst),
    .unit_req_i (unit_req),
    .bus_rsp_i  (wb_rsp_i),
    .unit_rsp_o (unit_rsp),
    .bus_req_o  (wb_req_o)
  );

endmodule

//--- hdl/wb_master_arbiter.sv
`timescale 1ns/100ps

/*
  Round-robin merge of the unit requests onto one Wishbone master port.
  A grant holds from lock until ack or err. The bus is idle for one cycle
  between grants while the next unit is picked.
*/
module wb_master_arbiter (
  input  logic            wb_clk_i,
  input  logic            wb_rst,
  input  wb_pkg::wb_req_t unit_req_i [dbg_pkg::NUM_UNITS],
  input  wb_pkg::wb_rsp_t bus_rsp_i,
  output wb_pkg::wb_rsp_t unit_rsp_o [dbg_pkg::NUM_UNITS],
  output wb_pkg::wb_req_t bus_req_o
);

  logic [dbg_pkg::UNIT_W-1:0] grant_q;
  logic [dbg_pkg::UNIT_W-1:0] grant_nxt;
  logic                       lock_q;
  logic                       req_any;
  logic                       bus_resp;
  int                         scan_idx;

  // Scan from the unit after the last one served
  always_comb begin
    grant_nxt = grant_q;
    req_any   = 1'b0;
    scan_idx  = 0;
    for (int k = 1; k <= dbg_pkg::NUM_UNITS; k++) begin
      scan_idx = (int'(grant_q) + k) % dbg_pkg::NUM_UNITS;
      // First requester found wins
      if (!req_any && unit_req_i[scan_idx].cyc) begin
        grant_nxt = scan_idx[dbg_pkg::UNIT_W-1:0];
        req_any   = 1'b1;
      end
    end
  end

  assign bus_resp = lock_q & (bus_rsp_i.ack | bus_rsp_i.err);

  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else if (!lock_q) begin
      if (req_any) begin
        grant_q <= grant_nxt;
        lock_q  <= 1'b1;
      end
    end else if (bus_resp) begin
      lock_q <= 1'b0;
    end
  end

  // Bus stays idle while unlocked
  always_comb begin
    bus_req_o = '0;
    if (lock_q) begin
      bus_req_o = unit_req_i[grant_q];
    end
  end

  // Ack and err to the granted unit only, data to all
  always_comb begin
    for (int i = 0; i < dbg_pkg::NUM_UNITS; i++) begin
      unit_rsp_o[i].dat = bus_rsp_i.dat;
      unit_rsp_o[i].ack = bus_rsp_i.ack & lock_q & (int'(grant_q) == i);
      unit_rsp_o[i].err = bus_rsp_i.err & lock_q & (int'(grant_q) == i);
    end
  end

endmodule

//--- hdl/wb_pkg.sv
/*
  Wishbone master request and slave response types.
  Classic single cycles only, so no cti or bte fields are carried.
*/
package wb_pkg;

  // Bus widths
  localparam int WB_AW   = 32;
  localparam int WB_DW   = 32;
  localparam int WB_SELW = 4;

  // Master to slave
  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [WB_AW-1:0]   adr;
    logic [WB_DW-1:0]   dat;
    logic [WB_SELW-1:0] sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic             ack;
    logic             err;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

//--- verif/tb_dbg_wb_subsys.sv
`timescale 1ns/100ps

/*
  Testbench for dbg_wb_subsys with a memory slave on the Wishbone port.
  A command goes only to a unit whose ready is high. Results are compared
  against a shadow of the slave memory; read data of err cycles are not checked.
*/
module tb_dbg_wb_subsys;

  localparam int TIMEOUT_CYC = 200;
  localparam int NUM_RAND    = 200;

  logic              wb_clk_i;
  logic              biu_clk_i;
  logic              wb_rst;
  dbg_pkg::dbg_req_t dbg_req;
  logic              dbg_strb;
  logic              dbg_rdy;
  logic [31:0]       dbg_rdata;
  logic              dbg_err;
  wb_pkg::wb_req_t   wb_req;
  wb_pkg::wb_rsp_t   wb_rsp;

  // Shadow of the slave memory
  logic [31:0] shadow [256];

  // Expected result per unit, armed once its command is accepted
  logic [dbg_pkg::NUM_UNITS-1:0] pending;
  logic [31:0]                   exp_rdata [dbg_pkg::NUM_UNITS];
  logic                          exp_err   [dbg_pkg::NUM_UNITS];
  logic                          exp_read  [dbg_pkg::NUM_UNITS];

  int          mism_cnt;
  int          fail_cnt;
  logic        run_over;

  dbg_wb_subsys i_dut (
    .wb_clk_i    (wb_clk_i),
    .biu_clk_i   (biu_clk_i),
    .wb_rst      (wb_rst),
    .dbg_req_i   (dbg_req),
    .dbg_strb_i  (dbg_strb),
    .dbg_rdy_o   (dbg_rdy),
    .dbg_rdata_o (dbg_rdata),
    .dbg_err_o   (dbg_err),
    .wb_req_o    (wb_req),
    .wb_rsp_i    (wb_rsp)
  );

  wb_mem_slave i_mem (
    .wb_clk_i (wb_clk_i),
    .wb_rst   (wb_rst),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #2 wb_clk_i = ~wb_clk_i;
  always #5 biu_clk_i = ~biu_clk_i;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Same start pattern as the slave memory
  function automatic logic [31:0] fill_word(input int i);
    logic [7:0] a;
    a = 8'(i);
    fill_word = {a ^ 8'h5a, ~a, a + 8'h3c, a * 8'd7};
  endfunction

  // Lane rules, little-endian; err for bit 31 addresses
  function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic [2:0] size,
                                           output logic err);
    logic [31:0] word;
    word = shadow[addr[9:2]];
    err  = addr[31];
    if (size == dbg_pkg::SZ_BYTE) begin
      ref_read = {24'h0, word[8*addr[1:0] +: 8]};
    end else if (size == dbg_pkg::SZ_HALF) begin
      ref_read = {16'h0, word[16*addr[1] +: 16]};
    end else begin
      ref_read = word;
    end
  endfunction

  // Sub-word write data come from the top bits
  function automatic void shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [2:0] size);
    if (!addr[31]) begin
      if (size == dbg_pkg::SZ_BYTE) begin
        shadow[addr[9:2]][8*addr[1:0] +: 8] = wdata[31:24];
      end else if (size == dbg_pkg::SZ_HALF) begin
        shadow[addr[9:2]][16*addr[1] +: 16] = wdata[31:16];
      end else begin
        shadow[addr[9:2]] = wdata;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare and end of run
  ////////////////////////////////////////////////////////////

  // Ready and result of the selected unit are stable at the falling edge
  always @(negedge biu_clk_i) begin
    if (pending[dbg_req.unit] && dbg_rdy) begin
      if (dbg_err !== exp_err[dbg_req.unit]) begin
        $display("Mismatch dbg_err_o unit %0d: got %h expected %h",
                 dbg_req.unit, dbg_err, exp_err[dbg_req.unit]);
        mism_cnt++;
      end
      if (exp_read[dbg_req.unit] && !exp_err[dbg_req.unit] &&
          dbg_rdata !== exp_rdata[dbg_req.unit]) begin
        $display("Mismatch dbg_rdata_o unit %0d: got %h expected %h",
                 dbg_req.unit, dbg_rdata, exp_rdata[dbg_req.unit]);
        mism_cnt++;
      end
      pending[dbg_req.unit] = 1'b0;
    end
  end

  always @(posedge run_over) begin
    $display("Errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, entered 1 ns after a biu_clk_i rise
  ////////////////////////////////////////////////////////////

  task automatic issue_cmd(input int u, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic we, input logic [2:0] size);
    logic [31:0] rd;
    logic        err;
    rd = ref_read(addr, size, err);
    if (we) begin
      shadow_write(addr, wdata, size);
    end
    exp_rdata[u]  = rd;
    exp_err[u]    = err;
    exp_read[u]   = !we;
    dbg_req.unit  = u[dbg_pkg::UNIT_W-1:0];
    dbg_req.addr  = addr;
    dbg_req.wdata = wdata;
    dbg_req.we    = we;
    dbg_req.size  = size;
    dbg_strb      = 1'b1;
    @(posedge biu_clk_i);
    #1;
    dbg_strb = 1'b0;
    // Ready must have dropped on acceptance
    if (dbg_rdy !== 1'b0) begin
      $display("Command to unit %0d was not accepted", u);
      fail_cnt++;
    end else begin
      pending[u] = 1'b1;
    end
  endtask

  task automatic wait_done(input int u);
    int cnt;
    dbg_req.unit = u[dbg_pkg::UNIT_W-1:0];
    cnt = 0;
    while (pending[u] && cnt < TIMEOUT_CYC) begin
      @(posedge biu_clk_i);
      #1;
      cnt++;
    end
    if (pending[u]) begin
      $display("Timeout: unit %0d did not return ready within %0d debug clocks",
               u, TIMEOUT_CYC);
      fail_cnt++;
      run_over = 1'b1;
    end
  endtask

  task automatic run_cmd(input int u, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic we, input logic [2:0] size);
    issue_cmd(u, addr, wdata, we, size);
    wait_done(u);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          u;
    logic [31:0] addr;
    logic [2:0]  sz;
    wb_clk_i  = 1'b0;
    biu_clk_i = 1'b0;
    wb_rst    = 1'b1;
    dbg_req   = '0;
    dbg_strb  = 1'b0;
    pending   = '0;
    mism_cnt  = 0;
    fail_cnt  = 0;
    run_over  = 1'b0;
    void'($urandom(32'ha063_a0fa));
    for (int i = 0; i < dbg_pkg::NUM_UNITS; i++) begin
      exp_rdata[i] = '0;
      exp_err[i]   = 1'b0;
      exp_read[i]  = 1'b0;
    end
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(i);
    end
    repeat (8) @(posedge wb_clk_i);
    #1 wb_rst = 1'b0;
    // Debug-side reset releases two clocks later
    repeat (4) @(posedge biu_clk_i);
    #1;

    // Ready high on both units, bus idle
    for (int k = 0; k < dbg_pkg::NUM_UNITS; k++) begin
      dbg_req.unit = k[dbg_pkg::UNIT_W-1:0];
      @(negedge biu_clk_i);
      if (dbg_rdy !== 1'b1) begin
        $display("Mismatch dbg_rdy_o unit %0d: got %h expected 1", k, dbg_rdy);
        mism_cnt++;
      end
      if (wb_req.cyc !== 1'b0) begin
        $display("Mismatch wb_req_o.cyc: got %h expected 0", wb_req.cyc);
        mism_cnt++;
      end
      @(posedge biu_clk_i);
      #1;
    end

    // Word write and read back
    run_cmd(0, 32'h40, 32'hdead_beef, 1'b1, dbg_pkg::SZ_WORD);
    run_cmd(0, 32'h40, 32'h0, 1'b0, dbg_pkg::SZ_WORD);

    // Bytes and halves at every lane
    for (int lane = 0; lane < 4; lane++) begin
      run_cmd(0, 32'h80 + lane, $urandom, 1'b1, dbg_pkg::SZ_BYTE);
      run_cmd(1, 32'h80, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
      run_cmd(1, 32'h90 + lane, 32'h0, 1'b0, dbg_pkg::SZ_BYTE);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      run_cmd(1, 32'h84 + lane, $urandom, 1'b1, dbg_pkg::SZ_HALF);
      run_cmd(0, 32'h84, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
      run_cmd(0, 32'ha0 + lane, 32'h0, 1'b0, dbg_pkg::SZ_HALF);
    end

    // Err response, then a good transfer clears it
    run_cmd(1, 32'h8000_0010, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
    run_cmd(1, 32'h10, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
    run_cmd(0, 32'h8000_0040, $urandom, 1'b1, dbg_pkg::SZ_WORD);
    run_cmd(0, 32'h40, 32'h0, 1'b0, dbg_pkg::SZ_WORD);

    // Both units in flight together
    issue_cmd(0, 32'h100, $urandom, 1'b1, dbg_pkg::SZ_WORD);
    issue_cmd(1, 32'h104, $urandom, 1'b1, dbg_pkg::SZ_WORD);
    wait_done(0);
    wait_done(1);
    issue_cmd(0, 32'h104, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
    issue_cmd(1, 32'h100, 32'h0, 1'b0, dbg_pkg::SZ_WORD);
    wait_done(0);
    wait_done(1);

    // Random mix, each unit in its own half of memory so overlap is safe
    for (int n = 0; n < NUM_RAND; n++) begin
      u    = int'($urandom % dbg_pkg::NUM_UNITS);
      sz   = 3'($urandom % 5);
      addr = {22'h0, u[0], 9'($urandom)};
      if ($urandom % 8 == 0) begin
        addr[31] = 1'b1;
      end
      wait_done(u);
      issue_cmd(u, addr, $urandom, 1'($urandom), sz);
    end
    wait_done(0);
    wait_done(1);

    run_over = 1'b1;
  end

endmodule

//--- verif/wb_mem_slave.sv
`timescale 1ns/100ps

/*
  Wishbone slave model with 256 words decoded from adr[9:2].
  Addresses with bit 31 set answer err and leave the memory untouched.
  Ack or err follows stb by one clock. Memory starts with an address pattern.
*/
module wb_mem_slave (
  input  logic            wb_clk_i,
  input  logic            wb_rst,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o
);

  logic [31:0] mem [256];
  logic [7:0]  idx;
  logic        hit;

  assign idx = wb_req_i.adr[9:2];

  // New access only while no response is out
  assign hit = wb_req_i.cyc & wb_req_i.stb & ~wb_rsp_o.ack & ~wb_rsp_o.err;

  // Every byte depends on the full word index
  initial begin
    logic [7:0] a;
    for (int i = 0; i < 256; i++) begin
      a = 8'(i);
      mem[i] = {a ^ 8'h5a, ~a, a + 8'h3c, a * 8'd7};
    end
  end

  always @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      wb_rsp_o <= '0;
    end else begin
      wb_rsp_o.ack <= hit & ~wb_req_i.adr[31];
      wb_rsp_o.err <= hit & wb_req_i.adr[31];
      if (hit) begin
        wb_rsp_o.dat <= mem[idx];
      end
    end
  end

  // Byte-select write
  always @(posedge wb_clk_i) begin
    if (hit && wb_req_i.we && !wb_req_i.adr[31]) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
        end
      end
    end
  end

endmodule
